// File: csrSubsystem.f
+incdir+sim
verilog/csrTreePkg.sv
verilog/csrBus.sv
verilog/csrTreeSplitter.sv
verilog/csrRegisterFile.sv
verilog/csrSubsystem.sv
sim/csrSubsystemTb.sv

// File: sim/csrTbChecks.svh
// compare tasks and error counters that the CSR tree testbench includes inside its top module
`ifndef CSR_TB_CHECKS_SVH
`define CSR_TB_CHECKS_SVH

  // whole response at the ready cycle
  task automatic checkResp(
    input csrTreePkg::csrResp expected,
    input csrTreePkg::csrResp actual,
    input string              label
  );
    if (actual !== expected) begin
      respErrors++;
      $display("FAIL %0t: %s ready/error/rdata %0b/%0b/%h, expected %0b/%0b/%h",
               $time, label, actual.ready, actual.error, actual.rdata,
               expected.ready, expected.error, expected.rdata);
    end
  endtask

  // cycles from the first sampling edge to the ready edge
  task automatic checkLatency(input int expected, input int actual, input string label);
    if (actual != expected) begin
      latencyErrors++;
      $display("FAIL %0t: %s answered after %0d cycles, expected %0d",
               $time, label, actual, expected);
    end
  endtask

  // exactly one ready pulse per request
  task automatic checkPulses(input int actual, input string label);
    if (actual != 1) begin
      pulseErrors++;
      $display("FAIL %0t: %s saw %0d ready pulses, expected 1", $time, label, actual);
    end
  endtask

  function automatic int totalErrors();
    return respErrors + latencyErrors + pulseErrors + missingErrors;
  endfunction

  // closing summary line
  task automatic reportCounts();
    $display("errors: response %0d, latency %0d, ready count %0d, missing ready %0d",
             respErrors, latencyErrors, pulseErrors, missingErrors);
  endtask

`endif

// File: sim/csrSubsystemTb.sv
// CSR tree testbench checking LFSR-driven host traffic against a shadow model of the leaves
`timescale 1ns/1ps
`default_nettype none

module csrSubsystemTb;

  localparam int ClockPeriod = 40;
  localparam int DriveDelay = 2; // after the rising edge
  localparam int ReadyWaitLimit = 10;
  localparam int RandomMix = 200;
  // sweep, writes, readback, word-0 writes, out of range, sweep, unmapped, random mix
  localparam int PlannedRequests = 32 + 24 + 28 + 4 + 16 + 32 + 16 + RandomMix;
  localparam int CycleLimit = 20 * PlannedRequests + 50;
  localparam logic [15:0] LfsrSeed = 16'd37633;

  logic                               clock;
  logic                               resetSync;
  logic                               read;
  logic                               write;
  logic [csrTreePkg::BlockIdBits-1:0] toBlock;
  logic [csrTreePkg::AddressBits-1:0] address;
  logic [csrTreePkg::DataBits-1:0]    wdata;
  logic                               ready;
  logic                               error;
  logic [csrTreePkg::DataBits-1:0]    rdata;

  // expected contents with word 0 unused for the identity
  logic [csrTreePkg::DataBits-1:0] shadow [csrTreePkg::Leaves][csrTreePkg::LeafWords];
  logic [15:0] lfsrState;
  int cycleCount = 0;
  int readyPulses = 0;
  int respErrors = 0;
  int latencyErrors = 0;
  int pulseErrors = 0;
  int missingErrors = 0;

  // results handed from the host task to the comparing process
  csrTreePkg::csrResp expectedQ [$];
  csrTreePkg::csrResp observedQ [$];
  int                 expectedLatQ [$];
  int                 observedLatQ [$];
  int                 pulseQ [$];
  string              labelQ [$];
  event               resultReady;

  `include "csrTbChecks.svh"

  csrSubsystem i_csrSubsystem (
    .clock     (clock),
    .resetSync (resetSync),
    .read      (read),
    .write     (write),
    .toBlock   (toBlock),
    .address   (address),
    .wdata     (wdata),
    .ready     (ready),
    .error     (error),
    .rdata     (rdata)
  );

  initial begin
    clock = 1'b0;
    forever begin
      #(ClockPeriod / 2) clock = ~clock;
    end
  end

  // taps 16, 14, 13, 11
  function automatic logic [15:0] lfsrNext(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  // one LFSR step per bit handed out
  function automatic logic [31:0] takeBits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsrState = lfsrNext(lfsrState);
      value = {value[30:0], lfsrState[0]};
    end
    return value;
  endfunction

  // key/mask match giving -1 when no leaf owns the block
  function automatic int routeLeaf(input logic [7:0] block);
    int leaf;
    leaf = -1;
    for (int i = 0; i < csrTreePkg::Leaves; i++) begin
      if ((block & ~csrTreePkg::LeafMask[i]) == csrTreePkg::LeafKey[i]) begin
        leaf = i;
      end
    end
    return leaf;
  endfunction

  // expected response that also applies writes to the shadow array
  function automatic csrTreePkg::csrResp referenceAccess(
    input logic        isWrite,
    input logic [7:0]  block,
    input logic [7:0]  addr,
    input logic [31:0] data
  );
    csrTreePkg::csrResp resp;
    int leaf;
    leaf = routeLeaf(block);
    resp = '0;
    resp.ready = 1'b1;
    if (leaf < 0 || addr >= csrTreePkg::LeafWords || (isWrite && addr == 0)) begin
      resp.error = 1'b1; // unmapped, out of range or identity write
    end else if (isWrite) begin
      shadow[leaf][addr[2:0]] = data;
    end else if (addr == 0) begin
      resp.rdata = csrTreePkg::IdBase + 32'(leaf);
    end else begin
      resp.rdata = shadow[leaf][addr[2:0]];
    end
    return resp;
  endfunction

  // leaf 3 answers any of blocks 4 to 7
  function automatic logic [7:0] blockForLeaf(input int leaf);
    if (leaf < 3) begin
      return 8'(leaf);
    end
    return 8'd4 + 8'(takeBits(2));
  endfunction

  // one full request that starts and ends 2 ns after a rising edge
  task automatic hostAccess(
    input logic        isWrite,
    input logic [7:0]  block,
    input logic [7:0]  addr,
    input logic [31:0] data
  );
    csrTreePkg::csrResp expected;
    csrTreePkg::csrResp observed;
    int latency;
    int pulsesBefore;
    bit seen;
    string label;
    label = $sformatf("%s block %0d address %0d", isWrite ? "write" : "read", block, addr);
    expected = referenceAccess(isWrite, block, addr, data);
    pulsesBefore = readyPulses;
    read = !isWrite;
    write = isWrite;
    toBlock = block;
    address = addr;
    wdata = data;
    observed = '0;
    seen = 1'b0;
    latency = 0;
    @(posedge clock); // first edge that samples the request
    while (!seen && latency < ReadyWaitLimit) begin
      @(posedge clock);
      latency++;
      #1;
      if (ready === 1'b1) begin
        seen = 1'b1;
        observed.ready = ready;
        observed.error = error;
        observed.rdata = rdata;
      end
    end
    #(DriveDelay - 1);
    read = 1'b0;
    write = 1'b0;
    @(posedge clock); // one idle cycle
    #(DriveDelay);
    if (!seen) begin
      missingErrors++;
      $display("no ready from the DUT within %0d cycles for %s at time %0t",
               ReadyWaitLimit, label, $time);
    end else begin
      expectedQ.push_back(expected);
      observedQ.push_back(observed);
      expectedLatQ.push_back(routeLeaf(block) < 0 ? 3 : 4);
      observedLatQ.push_back(latency);
      pulseQ.push_back(readyPulses - pulsesBefore);
      labelQ.push_back(label);
      ->resultReady;
    end
  endtask

  // every word of every leaf with leaf 3 through a random alias
  task automatic sweepLeaves();
    for (int leaf = 0; leaf < csrTreePkg::Leaves; leaf++) begin
      for (int w = 0; w < csrTreePkg::LeafWords; w++) begin
        hostAccess(1'b0, blockForLeaf(leaf), 8'(w), '0);
      end
    end
  endtask

  initial begin : compareResults
    string label;
    forever begin
      @(resultReady);
      while (observedQ.size() > 0) begin
        label = labelQ.pop_front();
        checkResp(expectedQ.pop_front(), observedQ.pop_front(), label);
        checkLatency(expectedLatQ.pop_front(), observedLatQ.pop_front(), label);
        checkPulses(pulseQ.pop_front(), label);
      end
    end
  end

  always @(negedge clock) begin
    if (ready === 1'b1) begin
      readyPulses++; // midway through the pulse
    end
  end

  always @(posedge clock) begin
    cycleCount++;
    if (cycleCount >= CycleLimit) begin
      $display("timeout: the run did not finish within %0d cycles", CycleLimit);
      reportCounts();
      $display("sim failed");
      $finish;
    end
  end

  initial begin : stimulus
    logic [7:0]  block;
    logic [7:0]  addr;
    logic        isWrite;
    resetSync = 1'b1;
    read = 1'b0;
    write = 1'b0;
    toBlock = '0;
    address = '0;
    wdata = '0;
    lfsrState = LfsrSeed;
    for (int l = 0; l < csrTreePkg::Leaves; l++) begin
      for (int w = 0; w < csrTreePkg::LeafWords; w++) begin
        shadow[l][w] = '0;
      end
    end
    repeat (2) @(posedge clock);
    #(DriveDelay);
    resetSync = 1'b0;

    // reset values and identity words
    sweepLeaves();

    // random writes to mapped words and a full readback
    for (int n = 0; n < 24; n++) begin
      block = blockForLeaf(int'(takeBits(2)));
      addr = 8'd1 + 8'(takeBits(3) % 7);
      hostAccess(1'b1, block, addr, takeBits(32));
    end
    for (int leaf = 0; leaf < csrTreePkg::Leaves; leaf++) begin
      for (int w = 1; w < csrTreePkg::LeafWords; w++) begin
        hostAccess(1'b0, blockForLeaf(leaf), 8'(w), '0);
      end
    end

    // identity writes and addresses past word 7 must not store
    for (int leaf = 0; leaf < csrTreePkg::Leaves; leaf++) begin
      hostAccess(1'b1, blockForLeaf(leaf), 8'd0, takeBits(32));
    end
    for (int n = 0; n < 16; n++) begin
      block = blockForLeaf(int'(takeBits(2)));
      addr = 8'd8 + 8'(takeBits(8) % 248);
      hostAccess(n[0], block, addr, takeBits(32));
    end
    sweepLeaves();

    // unmapped blocks answered by the splitter
    for (int n = 0; n < 4; n++) begin
      hostAccess(n[0], 8'd3, 8'(takeBits(3)), takeBits(32));
    end
    for (int n = 0; n < 12; n++) begin
      block = 8'd8 + 8'(takeBits(8) % 248);
      hostAccess(n[0], block, 8'(takeBits(3)), takeBits(32));
    end

    // long mix biased toward mapped blocks and valid words
    for (int n = 0; n < RandomMix; n++) begin
      isWrite = 1'(takeBits(1));
      block = takeBits(1) ? 8'(takeBits(3)) : 8'(takeBits(8));
      addr = (takeBits(2) != 0) ? 8'(takeBits(3)) : 8'(takeBits(8));
      hostAccess(isWrite, block, addr, takeBits(32));
    end

    repeat (2) @(posedge clock);
    reportCounts();
    if (totalErrors() == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/csrSubsystem.sv
// CSR tree top level, one host port fanned out by the splitter to four register-file leaves
`timescale 1ns/1ps
`default_nettype none

module csrSubsystem (
  input  logic                               clock,
  input  logic                               resetSync,
  input  logic                               read,
  input  logic                               write,
  input  logic [csrTreePkg::BlockIdBits-1:0] toBlock,
  input  logic [csrTreePkg::AddressBits-1:0] address,
  input  logic [csrTreePkg::DataBits-1:0]    wdata,
  output logic                               ready,
  output logic                               error,
  output logic [csrTreePkg::DataBits-1:0]    rdata
);

  csrBus upLink ();
  csrBus leafLink [csrTreePkg::Leaves] ();

  // host pins onto the upstream link
  assign upLink.req = '{
    read:    read,
    write:   write,
    toBlock: toBlock,
    address: address,
    wdata:   wdata
  };

  assign ready = upLink.resp.ready;
  assign error = upLink.resp.error;
  assign rdata = upLink.resp.rdata;

  csrTreeSplitter uSplitter (
    .clock     (clock),
    .resetSync (resetSync),
    .up        (upLink),
    .down      (leafLink)
  );

  // one leaf per splitter output, index picks the identity word
  for (genvar i = 0; i < csrTreePkg::Leaves; i++) begin : gLeaf
    csrRegisterFile #(
      .LeafIndex (i)
    ) uLeaf (
      .clock     (clock),
      .resetSync (resetSync),
      .bus       (leafLink[i])
    );
  end

endmodule

`default_nettype wire

// File: verilog/csrRegisterFile.sv
// one CSR leaf with eight words, word 0 a read-only identity and everything past word 7 an error
`timescale 1ns/1ps
`default_nettype none

module csrRegisterFile #(
  parameter int LeafIndex = 0
) (
  input logic   clock,
  input logic   resetSync,
  csrBus.device bus
);

  localparam int DataBits = csrTreePkg::DataBits;
  localparam int LeafWords = csrTreePkg::LeafWords;
  localparam int WordIndexBits = csrTreePkg::WordIndexBits;
  localparam logic [DataBits-1:0] IdWord = csrTreePkg::IdBase + DataBits'(LeafIndex);

  logic [DataBits-1:0]      words [1:LeafWords-1]; // word 0 has no storage
  logic [DataBits-1:0]      readWord;
  logic [WordIndexBits-1:0] wordIndex;
  logic                     request;
  logic                     inRange;
  logic                     writeToId;
  logic                     answered; // already responded to this request

  assign request = bus.req.read || bus.req.write;
  assign inRange = bus.req.address < LeafWords;
  assign wordIndex = bus.req.address[WordIndexBits-1:0];
  assign writeToId = bus.req.write && (wordIndex == '0);

  always_comb begin
    if (wordIndex == '0) begin
      readWord = IdWord;
    end else begin
      readWord = words[wordIndex];
    end
  end

  always_ff @(posedge clock) begin
    if (resetSync) begin
      bus.resp <= '0;
      answered <= 1'b0;
      for (int w = 1; w < LeafWords; w++) begin
        words[w] <= '0;
      end
    end else begin
      bus.resp.ready <= 1'b0;

      if (!request) begin
        answered <= 1'b0; // rearm once the request drops
      end else if (!answered) begin
        answered <= 1'b1;
        bus.resp.ready <= 1'b1;
        if (!inRange || writeToId) begin
          // nothing stored, no data back
          bus.resp.error <= 1'b1;
          bus.resp.rdata <= '0;
        end else if (bus.req.write) begin
          words[wordIndex] <= bus.req.wdata;
          bus.resp.error <= 1'b0;
          bus.resp.rdata <= '0; // writes return zero
        end else begin
          bus.resp.error <= 1'b0;
          bus.resp.rdata <= readWord;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/csrTreeSplitter.sv
// routes one upstream CSR request to a leaf by key/mask match and returns the registered response
`timescale 1ns/1ps
`default_nettype none

module csrTreeSplitter (
  input logic   clock,
  input logic   resetSync,
  csrBus.device up,
  csrBus.host   down [csrTreePkg::Leaves]
);

  localparam int Leaves = csrTreePkg::Leaves;

  typedef enum logic [1:0] {
    StIdle,
    StSelect,
    StAccess,
    StWait
  } stateT;

  stateT state;

  csrTreePkg::csrReq  held;             // captured upstream request
  logic [Leaves-1:0]  hit;              // combinational key match
  logic [Leaves-1:0]  select;           // registered one-hot leaf select
  logic               active;           // downstream request is being presented
  logic               upRequest;
  csrTreePkg::csrResp leafResp [Leaves];
  csrTreePkg::csrResp merged;

  assign upRequest = up.req.read || up.req.write;

  // key/mask decode of the held block number
  always_comb begin
    for (int i = 0; i < Leaves; i++) begin
      hit[i] = csrTreePkg::leafHit(held.toBlock, i);
    end
  end

  // only the selected leaf sees read/write
  for (genvar i = 0; i < Leaves; i++) begin : gDown
    assign down[i].req = '{
      read:    held.read && active && select[i],
      write:   held.write && active && select[i],
      toBlock: held.toBlock,
      address: held.address,
      wdata:   held.wdata
    };
    assign leafResp[i] = down[i].resp;
  end

  // lowest-numbered ready leaf wins the merge
  always_comb begin
    merged = '0;
    for (int i = Leaves - 1; i >= 0; i--) begin
      if (leafResp[i].ready) begin
        merged = leafResp[i];
      end
    end
  end

  // request capture in idle
  always_ff @(posedge clock) begin
    if (state == StIdle && upRequest) begin
      held <= up.req;
    end
  end

  always_ff @(posedge clock) begin
    if (resetSync) begin
      state <= StIdle;
      select <= '0;
      active <= 1'b0;
      up.resp <= '0;
    end else begin
      up.resp.ready <= 1'b0; // single-cycle pulse

      case (state)
        StIdle: begin
          if (upRequest) begin
            state <= StSelect;
          end
        end

        StSelect: begin
          select <= hit;
          state <= StAccess;
        end

        StAccess: begin
          active <= 1'b1;
          if (merged.ready) begin
            // pass the leaf's answer up one cycle later
            up.resp.ready <= 1'b1;
            up.resp.error <= merged.error;
            up.resp.rdata <= merged.rdata;
            active <= 1'b0;
            state <= StWait;
          end else if (active && select == '0) begin
            // nobody owns this block
            up.resp.ready <= 1'b1;
            up.resp.error <= 1'b1;
            up.resp.rdata <= '0;
            active <= 1'b0;
            state <= StWait;
          end
        end

        StWait: begin
          if (!upRequest) begin
            state <= StIdle; // host has let go
          end
        end

        default: begin
          state <= StIdle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verilog/csrBus.sv
// one CSR link inside the tree, host drives the request and the device answers
`timescale 1ns/1ps
`default_nettype none

interface csrBus;

  csrTreePkg::csrReq  req;  // held until ready is seen
  csrTreePkg::csrResp resp; // ready pulses once per request

  // requesting side, splitter downstream or top-level upstream
  modport host (
    output req,
    input  resp
  );

  // answering side, a leaf or the splitter's upstream port
  modport device (
    input  req,
    output resp
  );

endinterface

`default_nettype wire

// File: verilog/csrTreePkg.sv
// shared widths, request/response structs, routing table and identity words for the CSR tree
`default_nettype none

package csrTreePkg;

  localparam int BlockIdBits = 8; // target block number
  localparam int AddressBits = 8; // word address inside a block
  localparam int DataBits = 32;
  localparam int Leaves = 4; // splitter outputs
  localparam int LeafWords = 8; // words per leaf
  localparam int WordIndexBits = $clog2(LeafWords);

  // request from host toward a leaf
  typedef struct packed {
    logic                   read;
    logic                   write;
    logic [BlockIdBits-1:0] toBlock;
    logic [AddressBits-1:0] address;
    logic [DataBits-1:0]    wdata;
  } csrReq;

  // response back toward the host, ready is a one-cycle pulse
  typedef struct packed {
    logic                ready;
    logic                error;
    logic [DataBits-1:0] rdata;
  } csrResp;

  // routing table: leaf 3 covers blocks 4..7 through its mask
  localparam logic [BlockIdBits-1:0] LeafKey [0:Leaves-1] = '{8'd0, 8'd1, 8'd2, 8'd4};
  localparam logic [BlockIdBits-1:0] LeafMask [0:Leaves-1] = '{8'd0, 8'd0, 8'd0, 8'd3};

  // identity word base, leaf i reads IdBase + i at word 0
  localparam logic [DataBits-1:0] IdBase = 32'hC5A0_1000;

  // true when a block number falls inside the given leaf's key/mask window
  function automatic logic leafHit(input logic [BlockIdBits-1:0] toBlock, input int leaf);
    logic [BlockIdBits-1:0] masked;
    masked = toBlock & ~LeafMask[leaf];
    return masked == LeafKey[leaf];
  endfunction

endpackage

`default_nettype wire
